/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_noc_error_checker -f filelist.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/destination_checker.sv */
module destination_checker #(
  parameter int SIZE_X = 4,
  parameter int SIZE_Y = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           fifo_valid,
  input  noc_pkg::flit_t fifo_flit,
  output logic           fifo_ready,
  output logic           req_valid,
  output noc_pkg::flit_t req_flit,
  input  logic           req_ready,
  input  logic           rsp_valid,
  input  noc_pkg::flit_t rsp_flit,
  output logic           rsp_ready,
  output logic           mux_valid,
  output noc_pkg::flit_t mux_flit,
  input  logic           mux_ready
);

  typedef enum logic {
    ROUTE_NORMAL,
    ROUTE_ERROR
  } route_e;

  route_e route_latched;
  route_e route_next;
  route_e route;
  logic   invalid_dest;
  logic   error_busy;
  logic   start_of_packet;
  logic   fifo_pass;
  logic   normal_valid;
  logic   req_busy;
  logic   rsp_busy;
  logic   req_end;
  logic   rsp_end;

  assign invalid_dest =
    noc_pkg::get_invalid_dest(fifo_flit) ||
    (int'(noc_pkg::get_coord(fifo_flit, noc_pkg::DEST_X_LSB)) >= SIZE_X) ||
    (int'(noc_pkg::get_coord(fifo_flit, noc_pkg::DEST_Y_LSB)) >= SIZE_Y);

  assign error_busy      = req_busy || rsp_busy;
  assign start_of_packet = fifo_valid && noc_pkg::is_head(fifo_flit) && !error_busy;
  assign fifo_pass       = !(noc_pkg::is_head(fifo_flit) && error_busy); // hold the next head

  assign route_next = invalid_dest ? ROUTE_ERROR : ROUTE_NORMAL;
  assign route      = start_of_packet ? route_next : route_latched;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_latched <= ROUTE_NORMAL;
    end else if (start_of_packet) begin
      route_latched <= route_next;
    end
  end

  assign req_valid    = fifo_valid && fifo_pass && (route == ROUTE_ERROR);
  assign req_flit     = fifo_flit;
  assign normal_valid = fifo_valid && fifo_pass && (route == ROUTE_NORMAL) && !rsp_busy;

  always_comb begin
    if (!fifo_pass) begin
      fifo_ready = 1'b0;
    end else if (route == ROUTE_ERROR) begin
      fifo_ready = req_ready;
    end else begin
      fifo_ready = mux_ready && !rsp_busy;
    end
  end

  // the response takes the output while it is pending
  assign mux_valid = rsp_busy ? rsp_valid : normal_valid;
  assign mux_flit  = rsp_busy ? rsp_flit : fifo_flit;
  assign rsp_ready = rsp_busy && mux_ready;

  assign req_end = req_valid && req_ready && noc_pkg::is_tail(fifo_flit);
  assign rsp_end = rsp_valid && rsp_ready && noc_pkg::is_tail(rsp_flit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_busy <= 1'b0;
      rsp_busy <= 1'b0;
    end else begin
      if (req_end) begin
        req_busy <= 1'b0; // a single-flit request never sets it
      end else if (start_of_packet && invalid_dest) begin
        req_busy <= 1'b1;
      end
      if (rsp_end) begin
        rsp_busy <= 1'b0;
      end else if (start_of_packet && invalid_dest &&
                   noc_pkg::is_non_posted(noc_pkg::get_packet_type(fifo_flit))) begin
        rsp_busy <= 1'b1;
      end
    end
  end

endmodule

/* design/error_responder.sv */
module error_responder #(
  parameter logic [noc_pkg::DATA_WIDTH-1:0] ERROR_DATA = '0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_valid,
  input  noc_pkg::flit_t req_flit,
  output logic           req_ready,
  output logic           rsp_valid,
  output noc_pkg::flit_t rsp_flit,
  input  logic           rsp_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DRAIN,
    ST_RESP_HEAD,
    ST_RESP_DATA
  } state_e;

  state_e                            state;
  noc_pkg::packet_type_t             req_type;
  noc_pkg::node_coord_t              req_src_x;
  noc_pkg::node_coord_t              req_src_y;
  noc_pkg::node_coord_t              req_dst_x;
  noc_pkg::node_coord_t              req_dst_y;
  noc_pkg::tag_t                     req_tag;
  noc_pkg::burst_len_t               req_burst;
  noc_pkg::burst_len_t               data_count;
  logic [noc_pkg::DATA_WIDTH-1:0]    head_body;
  logic                              req_fire;
  logic                              rsp_fire;
  logic                              has_data;

  assign req_ready = (state == ST_IDLE) || (state == ST_DRAIN);
  assign rsp_valid = (state == ST_RESP_HEAD) || (state == ST_RESP_DATA);
  assign req_fire  = req_valid && req_ready;
  assign rsp_fire  = rsp_valid && rsp_ready;
  assign has_data  = (req_type == noc_pkg::PKT_READ) && (req_burst != '0);

  // only the head fields are kept, the payload is thrown away
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && req_fire) begin
      req_type  <= noc_pkg::get_packet_type(req_flit);
      req_src_x <= noc_pkg::get_coord(req_flit, noc_pkg::SRC_X_LSB);
      req_src_y <= noc_pkg::get_coord(req_flit, noc_pkg::SRC_Y_LSB);
      req_dst_x <= noc_pkg::get_coord(req_flit, noc_pkg::DEST_X_LSB);
      req_dst_y <= noc_pkg::get_coord(req_flit, noc_pkg::DEST_Y_LSB);
      req_tag   <= req_flit[noc_pkg::TAG_LSB +: $bits(noc_pkg::tag_t)];
      req_burst <= req_flit[noc_pkg::BURST_LEN_LSB +: $bits(noc_pkg::burst_len_t)];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      data_count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_fire) begin
            if (!noc_pkg::is_tail(req_flit)) begin
              state <= ST_DRAIN;
            end else if (noc_pkg::is_non_posted(noc_pkg::get_packet_type(req_flit))) begin
              state <= ST_RESP_HEAD;
            end
          end
        end
        ST_DRAIN: begin
          if (req_fire && noc_pkg::is_tail(req_flit)) begin
            if (noc_pkg::is_non_posted(req_type)) begin
              state <= ST_RESP_HEAD;
            end else begin
              state <= ST_IDLE; // posted write, nothing to answer
            end
          end
        end
        ST_RESP_HEAD: begin
          if (rsp_fire) begin
            if (has_data) begin
              state      <= ST_RESP_DATA;
              data_count <= req_burst;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        ST_RESP_DATA: begin
          if (rsp_fire) begin
            data_count <= data_count - 1'b1;
            if (data_count == 4'd1) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    head_body = '0;
    head_body[noc_pkg::PKT_TYPE_LSB +: 2] = noc_pkg::PKT_RESPONSE;
    head_body[noc_pkg::DEST_X_LSB +: 2]   = req_src_x; // back to the requester
    head_body[noc_pkg::DEST_Y_LSB +: 2]   = req_src_y;
    head_body[noc_pkg::SRC_X_LSB +: 2]    = req_dst_x;
    head_body[noc_pkg::SRC_Y_LSB +: 2]    = req_dst_y;
    head_body[noc_pkg::TAG_LSB +: 4]      = req_tag;
    head_body[noc_pkg::BURST_LEN_LSB +: 4] =
      (req_type == noc_pkg::PKT_READ) ? req_burst : 4'd0;
    head_body[noc_pkg::STATUS_LSB +: 2]   = noc_pkg::STATUS_DECODE_ERROR;
    if (state == ST_RESP_DATA) begin
      rsp_flit = {1'b0, (data_count == 4'd1), ERROR_DATA};
    end else begin
      rsp_flit = {1'b1, !has_data, head_body};
    end
  end

endmodule

/* design/flit_input_fifo.sv */
module flit_input_fifo (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  noc_pkg::flit_t in_flit,
  output logic           in_ready,
  output logic           fifo_valid,
  output noc_pkg::flit_t fifo_flit,
  input  logic           fifo_ready
);

  localparam int DEPTH = 2;

  noc_pkg::flit_t mem [DEPTH];
  logic           wr_ptr;
  logic           rd_ptr;
  logic [1:0]     count;
  logic           push;
  logic           pop;

  assign in_ready   = (count != 2'(DEPTH));
  assign fifo_valid = (count != 2'd0);
  assign fifo_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = fifo_valid && fifo_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr; // two entries, so the pointer just flips
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/flit_output_slice.sv */
module flit_output_slice (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           mux_valid,
  input  noc_pkg::flit_t mux_flit,
  output logic           mux_ready,
  output logic           out_valid,
  output noc_pkg::flit_t out_flit,
  input  logic           out_ready
);

  logic           main_valid;
  noc_pkg::flit_t main_flit;
  logic           skid_valid;
  noc_pkg::flit_t skid_flit;
  logic           mux_fire;

  assign mux_ready = !skid_valid; // registered, so the ready path stays short
  assign mux_fire  = mux_valid && mux_ready;
  assign out_valid = main_valid;
  assign out_flit  = main_flit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_ready || !main_valid) begin
      main_valid <= skid_valid || mux_fire;
      skid_valid <= 1'b0;
    end else if (mux_fire) begin
      skid_valid <= 1'b1; // output stalled, park the extra flit
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready || !main_valid) begin
      main_flit <= skid_valid ? skid_flit : mux_flit;
    end else if (mux_fire) begin
      skid_flit <= mux_flit;
    end
  end

endmodule

/* design/noc_error_checker_top.sv */
module noc_error_checker_top #(
  parameter int                             SIZE_X     = 4,
  parameter int                             SIZE_Y     = 4,
  parameter logic [noc_pkg::DATA_WIDTH-1:0] ERROR_DATA = 32'hbad0_da7a
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  noc_pkg::flit_t in_flit,
  output logic           in_ready,
  output logic           out_valid,
  output noc_pkg::flit_t out_flit,
  input  logic           out_ready
);

  logic           fifo_valid;
  logic           fifo_ready;
  noc_pkg::flit_t fifo_flit;
  logic           req_valid;
  logic           req_ready;
  noc_pkg::flit_t req_flit;
  logic           rsp_valid;
  logic           rsp_ready;
  noc_pkg::flit_t rsp_flit;
  logic           mux_valid;
  logic           mux_ready;
  noc_pkg::flit_t mux_flit;

  flit_input_fifo u_input_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_flit    (in_flit),
    .in_ready   (in_ready),
    .fifo_valid (fifo_valid),
    .fifo_flit  (fifo_flit),
    .fifo_ready (fifo_ready)
  );

  destination_checker #(
    .SIZE_X (SIZE_X),
    .SIZE_Y (SIZE_Y)
  ) u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_valid (fifo_valid),
    .fifo_flit  (fifo_flit),
    .fifo_ready (fifo_ready),
    .req_valid  (req_valid),
    .req_flit   (req_flit),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_flit   (rsp_flit),
    .rsp_ready  (rsp_ready),
    .mux_valid  (mux_valid),
    .mux_flit   (mux_flit),
    .mux_ready  (mux_ready)
  );

  error_responder #(
    .ERROR_DATA (ERROR_DATA)
  ) u_responder (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_flit  (req_flit),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_flit  (rsp_flit),
    .rsp_ready (rsp_ready)
  );

  flit_output_slice u_output_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .mux_valid (mux_valid),
    .mux_flit  (mux_flit),
    .mux_ready (mux_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

endmodule

/* design/noc_pkg.sv */
package noc_pkg;

  typedef logic [33:0] flit_t;
  typedef logic [1:0]  node_coord_t;
  typedef logic [1:0]  packet_type_t;
  typedef logic [3:0]  burst_len_t;
  typedef logic [3:0]  tag_t;
  typedef logic [1:0]  status_t;

  localparam int HEAD_BIT   = 33;
  localparam int TAIL_BIT   = 32;
  localparam int DATA_WIDTH = 32;

  // head flit body fields, low bit of each
  localparam int PKT_TYPE_LSB     = 0;
  localparam int DEST_X_LSB       = 2;
  localparam int DEST_Y_LSB       = 4;
  localparam int SRC_X_LSB        = 6;
  localparam int SRC_Y_LSB        = 8;
  localparam int TAG_LSB          = 10;
  localparam int BURST_LEN_LSB    = 14;
  localparam int STATUS_LSB       = 18;
  localparam int INVALID_DEST_BIT = 20;

  localparam packet_type_t PKT_READ         = 2'd0;
  localparam packet_type_t PKT_WRITE_POSTED = 2'd1;
  localparam packet_type_t PKT_WRITE_NP     = 2'd2;
  localparam packet_type_t PKT_RESPONSE     = 2'd3;

  localparam status_t STATUS_OK           = 2'd0;
  localparam status_t STATUS_DECODE_ERROR = 2'd1;

  function automatic logic is_head(flit_t flit);
    return flit[HEAD_BIT];
  endfunction

  function automatic logic is_tail(flit_t flit);
    return flit[TAIL_BIT];
  endfunction

  function automatic packet_type_t get_packet_type(flit_t flit);
    return flit[PKT_TYPE_LSB +: $bits(packet_type_t)];
  endfunction

  function automatic node_coord_t get_coord(flit_t flit, int lsb);
    return flit[lsb +: $bits(node_coord_t)];
  endfunction

  function automatic logic get_invalid_dest(flit_t flit);
    return flit[INVALID_DEST_BIT];
  endfunction

  // reads and non-posted writes expect an answer
  function automatic logic is_non_posted(packet_type_t pkt_type);
    return (pkt_type == PKT_READ) || (pkt_type == PKT_WRITE_NP);
  endfunction

endpackage

/* filelist.f */
design/noc_pkg.sv
design/flit_input_fifo.sv
design/destination_checker.sv
design/error_responder.sv
design/flit_output_slice.sv
design/noc_error_checker_top.sv
tests/tb_noc_error_checker.sv

/* tests/tb_noc_error_checker.sv */
module tb_noc_error_checker;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          MESH_X   = 3; // smaller than the coordinate range, so x = 3 is off-mesh
  localparam int          MESH_Y   = 3;
  localparam logic [31:0] ERR_DATA = 32'hdead_e770;
  localparam int          TIMEOUT  = 1000;

  logic           clk;
  logic           rst_n;
  logic           in_valid;
  noc_pkg::flit_t in_flit;
  logic           in_ready;
  logic           out_valid;
  noc_pkg::flit_t out_flit;
  logic           out_ready;

  noc_pkg::flit_t expected_q[$];
  int             cycle;
  integer         seed;
  logic           random_ready;
  logic           timed_check;
  int             timed_cycle;

  noc_error_checker_top #(
    .SIZE_X     (MESH_X),
    .SIZE_Y     (MESH_Y),
    .ERROR_DATA (ERR_DATA)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (random_ready) begin
      out_ready <= 1'($random(seed));
    end
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [33:0] actual,
                             input logic [33:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch at %0t: %s actual %h expected %h",
                               $time, name, actual, expected));
    end
  endtask

  // every output transfer must match the head of the expected queue
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        report_failure($sformatf("unexpected flit %h on out_flit at %0t", out_flit, $time));
      end else begin
        check_value("out_flit", out_flit, expected_q.pop_front());
        if (timed_check) begin
          check_value("out_valid cycle", 34'(cycle), 34'(timed_cycle));
          timed_check = 1'b0;
        end
      end
    end
  end

  function automatic logic [31:0] make_head_body(
    input logic [1:0] ptype,
    input logic [1:0] dx,
    input logic [1:0] dy,
    input logic [1:0] sx,
    input logic [1:0] sy,
    input logic [3:0] tag,
    input logic [3:0] burst,
    input logic [1:0] status,
    input logic       inv
  );
    logic [31:0] body;
    body = '0;
    body[noc_pkg::PKT_TYPE_LSB +: 2]  = ptype;
    body[noc_pkg::DEST_X_LSB +: 2]    = dx;
    body[noc_pkg::DEST_Y_LSB +: 2]    = dy;
    body[noc_pkg::SRC_X_LSB +: 2]     = sx;
    body[noc_pkg::SRC_Y_LSB +: 2]     = sy;
    body[noc_pkg::TAG_LSB +: 4]       = tag;
    body[noc_pkg::BURST_LEN_LSB +: 4] = burst;
    body[noc_pkg::STATUS_LSB +: 2]    = status;
    body[noc_pkg::INVALID_DEST_BIT]   = inv;
    return body;
  endfunction

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_flit(input noc_pkg::flit_t flit, output int accept_cycle);
    int waited;
    waited = 0;
    in_valid <= 1'b1;
    in_flit  <= flit;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        report_failure("timeout while waiting for in_ready to accept a flit");
      end
    end while (!in_ready);
    accept_cycle = cycle;
  endtask

  task automatic send_packet(input logic [1:0] ptype, input logic [1:0] dx, input logic [1:0] dy,
                             input logic [1:0] sx, input logic [1:0] sy, input logic [3:0] tag,
                             input logic [3:0] burst, input logic inv, input int payload,
                             output int head_cycle);
    noc_pkg::flit_t flits[$];
    logic [31:0]    rsp_body;
    int             c;
    head_cycle = 0;
    flits.push_back({1'b1, payload == 0,
                     make_head_body(ptype, dx, dy, sx, sy, tag, burst, noc_pkg::STATUS_OK, inv)});
    for (int i = 0; i < payload; i++) begin
      flits.push_back({1'b0, i == payload - 1, 32'hc0de_0000 | 32'({tag, 8'(i)})});
    end
    rsp_body = make_head_body(noc_pkg::PKT_RESPONSE, sx, sy, dx, dy, tag,
                              (ptype == noc_pkg::PKT_READ) ? burst : 4'd0,
                              noc_pkg::STATUS_DECODE_ERROR, 1'b0);
    if (!inv && int'(dx) < MESH_X && int'(dy) < MESH_Y) begin
      foreach (flits[i]) begin
        expected_q.push_back(flits[i]);
      end
    end else if (ptype == noc_pkg::PKT_READ) begin
      expected_q.push_back({1'b1, burst == 4'd0, rsp_body});
      for (int i = 1; i <= int'(burst); i++) begin
        expected_q.push_back({1'b0, i == int'(burst), ERR_DATA});
      end
    end else if (ptype == noc_pkg::PKT_WRITE_NP) begin
      expected_q.push_back({2'b11, rsp_body});
    end
    foreach (flits[i]) begin
      send_flit(flits[i], c);
      if (i == 0) begin
        head_cycle = c;
      end
    end
    in_valid <= 1'b0; // overridden when the next packet follows at once
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        report_failure($sformatf("timeout while waiting for the output of %s", what));
      end
    end
  endtask

  task automatic pass_through_order();
    int h;
    check_value("in_ready", 34'(in_ready), 34'(1));
    check_value("out_valid", 34'(out_valid), 34'(0));
    send_packet(noc_pkg::PKT_WRITE_POSTED, 2'd1, 2'd2, 2'd0, 2'd0, 4'd1, 4'd0, 1'b0, 0, h);
    timed_cycle = h + 2;
    timed_check = 1'b1;
    send_packet(noc_pkg::PKT_WRITE_NP, 2'd2, 2'd0, 2'd1, 2'd1, 4'd2, 4'd2, 1'b0, 2, h);
    wait_drain("pass-through packets");
  endtask

  task automatic read_decode_error();
    int h;
    send_packet(noc_pkg::PKT_READ, 2'(MESH_X), 2'd1, 2'd2, 2'd0, 4'd5, 4'd4, 1'b0, 0, h);
    wait_drain("read decode error");
  endtask

  task automatic np_write_invalid_flag();
    int h;
    send_packet(noc_pkg::PKT_WRITE_NP, 2'd1, 2'd1, 2'd0, 2'd2, 4'd9, 4'd2, 1'b1, 2, h);
    wait_drain("non-posted write with invalid flag");
  endtask

  task automatic posted_write_drop();
    int h;
    send_packet(noc_pkg::PKT_WRITE_POSTED, 2'd0, 2'(MESH_Y), 2'd1, 2'd0, 4'd3, 4'd3, 1'b0, 3, h);
    send_packet(noc_pkg::PKT_WRITE_POSTED, 2'd2, 2'd2, 2'd0, 2'd1, 4'd4, 4'd1, 1'b0, 1, h);
    wait_drain("dropped posted write");
  endtask

  task automatic run_mix(input string what);
    int h;
    send_packet(noc_pkg::PKT_WRITE_NP, 2'd0, 2'd1, 2'd2, 2'd2, 4'd6, 4'd2, 1'b0, 2, h);
    send_packet(noc_pkg::PKT_READ, 2'd3, 2'd0, 2'd1, 2'd2, 4'd7, 4'd2, 1'b0, 0, h);
    send_packet(noc_pkg::PKT_READ, 2'd1, 2'd1, 2'd0, 2'd0, 4'd8, 4'd3, 1'b0, 0, h);
    send_packet(noc_pkg::PKT_WRITE_POSTED, 2'd2, 2'd0, 2'd1, 2'd1, 4'd10, 4'd1, 1'b1, 1, h);
    send_packet(noc_pkg::PKT_WRITE_NP, 2'd1, 2'd3, 2'd0, 2'd1, 4'd11, 4'd1, 1'b0, 1, h);
    send_packet(noc_pkg::PKT_WRITE_POSTED, 2'd2, 2'd1, 2'd2, 2'd0, 4'd12, 4'd3, 1'b0, 3, h);
    send_packet(noc_pkg::PKT_READ, 2'd0, 2'd0, 2'd2, 2'd1, 4'd13, 4'd1, 1'b1, 0, h);
    wait_drain(what);
  endtask

  task automatic mix_with_backpressure();
    random_ready <= 1'b1;
    run_mix("mixed traffic under back-pressure");
    random_ready <= 1'b0;
    @(posedge clk);
    out_ready <= 1'b1;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_flit      = '0;
    out_ready    = 1'b1;
    random_ready = 1'b0;
    timed_check  = 1'b0;
    timed_cycle  = 0;
    cycle        = 0;
    seed         = 91;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    pass_through_order();
    read_decode_error();
    np_write_invalid_flag();
    posted_write_drop();
    run_mix("mixed traffic");
    mix_with_backpressure();
    $display("Test completed successfully");
    $finish;
  end

endmodule
